// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := periph_hub_tb
FILELIST  := periph_hub.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== periph_hub.f ====
source/periph_hub_pkg.sv
source/periph_bus_decode.sv
source/periph_read_reg.sv
source/gpio_config.sv
source/pin_output_mux.sv
source/tick_timer.sv
source/pwm_byte.sv
source/periph_hub.sv
tb/periph_hub_chk.sv
tb/periph_hub_tb.sv

// ==== source/gpio_config.sv ====
`timescale 1ns/10ps
`default_nettype none
//********************
// GPIO registers in full slot 1
// Writes of any size use the low bits of the data
// Pins 0 and 1 reset to the timer, the rest to GPIO
//********************

module gpio_config (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire [5:0]                          i_addr_ofs,
    input  wire [periph_hub_pkg::DATA_W-1:0]   i_data_in,
    input  wire [1:0]                          i_write_n,
    input  wire [7:0]                          i_ui_in,
    output logic [periph_hub_pkg::DATA_W-1:0]  o_read_data,
    output logic [7:0]                         o_gpio_out,
    output logic [periph_hub_pkg::PIN_W-1:0][periph_hub_pkg::FUNC_SEL_W-1:0] o_func_sel,
    output periph_hub_pkg::audio_src_e         o_audio_src,
    output logic                               o_audio_select
);

    logic       wr;
    logic       func_hit;
    logic [2:0] pin_idx;
    logic [3:0] audio_sel;    // Bit 3 enables the audio output

    assign wr       = (i_write_n != periph_hub_pkg::SIZE_NONE);
    assign func_hit = ((i_addr_ofs & 6'h23) == periph_hub_pkg::FUNC_SEL_OFS);
    assign pin_idx  = i_addr_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
            audio_sel  <= '0;
        end else if (wr) begin
            if (i_addr_ofs == periph_hub_pkg::GPIO_OUT_OFS)
                o_gpio_out <= i_data_in[7:0];
            if (i_addr_ofs == periph_hub_pkg::AUDIO_SEL_OFS)
                audio_sel <= i_data_in[3:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int n = 0; n < periph_hub_pkg::PIN_W; n++) begin
                if (n < 2)
                    o_func_sel[n] <= {1'b0, periph_hub_pkg::SLOT_TIMER};
                else
                    o_func_sel[n] <= {1'b0, periph_hub_pkg::SLOT_GPIO};
            end
        end else if (wr && func_hit) begin
            o_func_sel[pin_idx] <= i_data_in[periph_hub_pkg::FUNC_SEL_W-1:0];
        end
    end

    always_comb begin
        o_read_data = '0;
        if (func_hit)
            o_read_data[periph_hub_pkg::FUNC_SEL_W-1:0] = o_func_sel[pin_idx];
        else if (i_addr_ofs == periph_hub_pkg::GPIO_OUT_OFS)
            o_read_data[7:0] = o_gpio_out;
        else if (i_addr_ofs == periph_hub_pkg::GPIO_IN_OFS)
            o_read_data[7:0] = i_ui_in;
        else if (i_addr_ofs == periph_hub_pkg::AUDIO_SEL_OFS)
            o_read_data[3:0] = audio_sel;
    end

    assign o_audio_src    = periph_hub_pkg::audio_src_e'(audio_sel[2:0]);
    assign o_audio_select = audio_sel[3];

endmodule

`default_nettype wire

// ==== source/periph_bus_decode.sv ====
`timescale 1ns/10ps
`default_nettype none
//********************
// Address decode for the full and byte slots
// Read codes come in already masked by the read register
// Empty slots and the unmapped top read zero with ready high
//********************

module periph_bus_decode (
    input  wire [periph_hub_pkg::ADDR_W-1:0]  i_addr,
    input  wire [1:0]                         i_data_write_n,
    input  wire [1:0]                         i_data_read_n,
    input  wire [periph_hub_pkg::DATA_W-1:0]  i_gpio_data,
    input  wire [periph_hub_pkg::DATA_W-1:0]  i_timer_data,
    input  wire                               i_timer_ready,
    input  wire [7:0]                         i_pwm_data,
    output logic [1:0]                        o_gpio_write_n,
    output logic [1:0]                        o_gpio_read_n,
    output logic [1:0]                        o_timer_write_n,
    output logic [1:0]                        o_timer_read_n,
    output logic                              o_pwm_write,
    output logic [periph_hub_pkg::DATA_W-1:0] o_peri_data,
    output logic                              o_peri_ready
);

    periph_hub_pkg::region_e region;
    logic [$clog2(periph_hub_pkg::FULL_SLOTS)-1:0]   full_slot;
    logic [$clog2(periph_hub_pkg::SIMPLE_SLOTS)-1:0] simple_slot;
    logic gpio_sel;
    logic timer_sel;
    logic pwm_sel;

    always_comb begin
        if (!i_addr[10])
            region = periph_hub_pkg::REGION_FULL;
        else if (!i_addr[9])
            region = periph_hub_pkg::REGION_SIMPLE;
        else
            region = periph_hub_pkg::REGION_NONE;
    end

    assign full_slot   = i_addr[9:6];
    assign simple_slot = i_addr[7:4];    // Bit 8 aliases

    assign gpio_sel  = (region == periph_hub_pkg::REGION_FULL) &&
                       (full_slot == periph_hub_pkg::SLOT_GPIO);
    assign timer_sel = (region == periph_hub_pkg::REGION_FULL) &&
                       (full_slot == periph_hub_pkg::SLOT_TIMER);
    assign pwm_sel   = (region == periph_hub_pkg::REGION_SIMPLE) &&
                       (simple_slot == periph_hub_pkg::SLOT_PWM);

    // Unselected slots see the idle code
    assign o_gpio_write_n  = i_data_write_n | {2{~gpio_sel}};
    assign o_gpio_read_n   = i_data_read_n  | {2{~gpio_sel}};
    assign o_timer_write_n = i_data_write_n | {2{~timer_sel}};
    assign o_timer_read_n  = i_data_read_n  | {2{~timer_sel}};
    assign o_pwm_write     = pwm_sel && (i_data_write_n != periph_hub_pkg::SIZE_NONE);

    always_comb begin
        o_peri_data  = '0;
        o_peri_ready = 1'b1;    // Only the timer takes a cycle
        if (gpio_sel) begin
            o_peri_data = i_gpio_data;
        end else if (timer_sel) begin
            o_peri_data  = i_timer_data;
            o_peri_ready = i_timer_ready;
        end else if (pwm_sel) begin
            o_peri_data = {{(periph_hub_pkg::DATA_W-8){1'b0}}, i_pwm_data};
        end
    end

endmodule

`default_nettype wire

// ==== source/periph_hub.sv ====
`timescale 1ns/10ps
`default_nettype none
//********************
// Peripheral bus wrapper of the microcontroller
// Reads are held until the core pulses read complete
// Only interrupt 2 (timer) is live, 3 to 15 are tied low
//********************

module periph_hub (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire [7:0]                         i_ui_in,    // Already synchronized
    input  wire [periph_hub_pkg::ADDR_W-1:0]  i_addr,
    input  wire [periph_hub_pkg::DATA_W-1:0]  i_data_in,
    input  wire [1:0]                         i_data_write_n,
    input  wire [1:0]                         i_data_read_n,
    input  wire                               i_data_read_complete,
    output logic [periph_hub_pkg::DATA_W-1:0] o_data_out,
    output logic                              o_data_ready,
    output logic [7:0]                        o_uo_out,
    output logic                              o_audio,
    output logic                              o_audio_select,
    output logic [15:2]                       o_user_interrupts
);

    logic [1:0]                        read_n_masked;
    logic [periph_hub_pkg::DATA_W-1:0] peri_data;
    logic                              peri_ready;
    logic [1:0]                        gpio_write_n;
    logic [1:0]                        timer_write_n;
    logic [1:0]                        timer_read_n;
    logic                              pwm_write;
    logic [periph_hub_pkg::DATA_W-1:0] gpio_data;
    logic [periph_hub_pkg::DATA_W-1:0] timer_data;
    logic                              timer_ready;
    logic [7:0]                        pwm_data;
    logic [7:0]                        gpio_out;
    logic [7:0]                        timer_pins;
    logic [7:0]                        pwm_pins;
    logic                              timer_irq;
    periph_hub_pkg::audio_src_e        audio_src;
    logic [periph_hub_pkg::PIN_W-1:0][periph_hub_pkg::FUNC_SEL_W-1:0] func_sel;

    periph_bus_decode u_decode (
        .i_addr          (i_addr),
        .i_data_write_n  (i_data_write_n),
        .i_data_read_n   (read_n_masked),
        .i_gpio_data     (gpio_data),
        .i_timer_data    (timer_data),
        .i_timer_ready   (timer_ready),
        .i_pwm_data      (pwm_data),
        .o_gpio_write_n  (gpio_write_n),
        .o_gpio_read_n   (),    // GPIO reads are combinational
        .o_timer_write_n (timer_write_n),
        .o_timer_read_n  (timer_read_n),
        .o_pwm_write     (pwm_write),
        .o_peri_data     (peri_data),
        .o_peri_ready    (peri_ready)
    );

    periph_read_reg u_read_reg (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_complete (i_data_read_complete),
        .i_peri_data          (peri_data),
        .i_peri_ready         (peri_ready),
        .o_read_n_masked      (read_n_masked),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    gpio_config u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_addr_ofs     (i_addr[5:0]),
        .i_data_in      (i_data_in),
        .i_write_n      (gpio_write_n),
        .i_ui_in        (i_ui_in),
        .o_read_data    (gpio_data),
        .o_gpio_out     (gpio_out),
        .o_func_sel     (func_sel),
        .o_audio_src    (audio_src),
        .o_audio_select (o_audio_select)
    );

    pin_output_mux u_pin_mux (
        .clk          (clk),
        .i_func_sel   (func_sel),
        .i_audio_src  (audio_src),
        .i_gpio_out   (gpio_out),
        .i_timer_pins (timer_pins),
        .i_pwm_pins   (pwm_pins),
        .o_uo_out     (o_uo_out),
        .o_audio      (o_audio)
    );

    tick_timer u_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_addr_ofs  (i_addr[5:0]),
        .i_data_in   (i_data_in),
        .i_write_n   (timer_write_n),
        .i_read_n    (timer_read_n),
        .o_read_data (timer_data),
        .o_ready     (timer_ready),
        .o_pins      (timer_pins),
        .o_interrupt (timer_irq)
    );

    pwm_byte u_pwm (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_addr_ofs  (i_addr[3:0]),
        .i_data_in   (i_data_in[7:0]),
        .i_write     (pwm_write),
        .o_read_data (pwm_data),
        .o_pins      (pwm_pins)
    );

    assign o_user_interrupts = {13'h0, timer_irq};

endmodule

`default_nettype wire

// ==== source/periph_hub_pkg.sv ====
`default_nettype none
//********************
// Address map and shared codes of the peripheral hub
// Full slots are 64 bytes and take 8, 16 or 32 bit accesses
// Byte slots are 16 bytes and take byte accesses only
// Only full slots 1 and 2 and byte slot 4 are populated
//********************

package periph_hub_pkg;

    localparam int ADDR_W       = 11;
    localparam int DATA_W       = 32;
    localparam int PIN_W        = 8;
    localparam int FULL_SLOTS   = 16;
    localparam int SIMPLE_SLOTS = 16;

    localparam logic [3:0] SLOT_GPIO  = 4'd1;
    localparam logic [3:0] SLOT_TIMER = 4'd2;
    localparam logic [3:0] SLOT_PWM   = 4'd4;    // Byte bank

    // Access size codes from the core
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_NONE = 2'b11;    // 10 is a full word

    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] AUDIO_SEL_OFS = 6'h10;
    localparam logic [5:0] FUNC_SEL_OFS  = 6'h20;    // Pin n at 0x20 + 4n

    localparam logic [5:0] TIMER_COUNT_OFS  = 6'h00;
    localparam logic [5:0] TIMER_STATUS_OFS = 6'h04;

    // Bit 4 picks the byte bank, bits 3:0 the slot
    localparam int FUNC_SEL_W = 5;

    typedef enum logic [1:0] {
        REGION_FULL,
        REGION_SIMPLE,
        REGION_NONE
    } region_e;

    typedef enum logic [2:0] {
        AUDIO_PWM   = 3'd0,
        AUDIO_GPIO7 = 3'd1
    } audio_src_e;

endpackage

`default_nettype wire

// ==== source/periph_read_reg.sv ====
`timescale 1ns/10ps
`default_nettype none
//********************
// Read data register toward the core
// Data is held from the first ready cycle until read complete
// The core must release the read with the completion pulse
//********************

module periph_read_reg (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire [1:0]                         i_data_read_n,
    input  wire [1:0]                         i_data_write_n,
    input  wire                               i_data_read_complete,
    input  wire [periph_hub_pkg::DATA_W-1:0]  i_peri_data,
    input  wire                               i_peri_ready,
    output logic [1:0]                        o_read_n_masked,
    output logic [periph_hub_pkg::DATA_W-1:0] o_data_out,
    output logic                              o_data_ready
);

    logic read_req;
    logic capture;
    logic hold;
    logic ready_r;

    assign read_req = (i_data_read_n != periph_hub_pkg::SIZE_NONE);
    assign capture  = read_req && i_peri_ready && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete)
                hold <= 1'b0;
            if (capture)
                hold <= 1'b1;
            // Held data keeps ready up even once the peripheral drops it
            ready_r <= read_req && (i_peri_ready || hold);
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            o_data_out <= i_peri_data;
    end

    // No second read reaches a peripheral while the result is waiting
    assign o_read_n_masked = i_data_read_n | {2{ready_r}};
    assign o_data_ready    = ready_r || (i_data_write_n != periph_hub_pkg::SIZE_NONE);

endmodule

`default_nettype wire

// ==== source/pin_output_mux.sv ====
`timescale 1ns/10ps
`default_nettype none
//********************
// Per-pin output select and the audio bit
// Pin outputs are combinational, audio is one cycle late
// Unpopulated slots drive 0
//********************

module pin_output_mux (
    input  wire                               clk,
    input  wire [periph_hub_pkg::PIN_W-1:0][periph_hub_pkg::FUNC_SEL_W-1:0] i_func_sel,
    input  wire periph_hub_pkg::audio_src_e   i_audio_src,
    input  wire [7:0]                         i_gpio_out,
    input  wire [7:0]                         i_timer_pins,
    input  wire [7:0]                         i_pwm_pins,
    output logic [7:0]                        o_uo_out,
    output logic                              o_audio
);

    always_comb begin
        for (int n = 0; n < periph_hub_pkg::PIN_W; n++) begin
            o_uo_out[n] = 1'b0;
            if (i_func_sel[n][4]) begin
                // Byte bank
                if (i_func_sel[n][3:0] == periph_hub_pkg::SLOT_PWM)
                    o_uo_out[n] = i_pwm_pins[n];
            end else if (i_func_sel[n][3:0] == periph_hub_pkg::SLOT_GPIO) begin
                o_uo_out[n] = i_gpio_out[n];
            end else if (i_func_sel[n][3:0] == periph_hub_pkg::SLOT_TIMER) begin
                o_uo_out[n] = i_timer_pins[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        case (i_audio_src)
            periph_hub_pkg::AUDIO_PWM:   o_audio <= i_pwm_pins[0];
            periph_hub_pkg::AUDIO_GPIO7: o_audio <= i_gpio_out[7];
            default:                     o_audio <= 1'b0;    // Free codes
        endcase
    end

endmodule

`default_nettype wire

// ==== source/pwm_byte.sv ====
`timescale 1ns/10ps
`default_nettype none
//********************
// 8-bit PWM in byte slot 4
// Duty 0 is always low, 255 is high for 255 of 256 cycles
//********************

module pwm_byte (
    input  wire        clk,
    input  wire        rst_n,
    input  wire [3:0]  i_addr_ofs,
    input  wire [7:0]  i_data_in,
    input  wire        i_write,
    output logic [7:0] o_read_data,
    output logic [7:0] o_pins
);

    logic [7:0] duty;
    logic [7:0] cnt;    // Free running

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty <= '0;
            cnt  <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            if (i_write && i_addr_ofs == 4'd0)
                duty <= i_data_in;
        end
    end

    assign o_read_data = (i_addr_ofs == 4'd0) ? duty : 8'h00;
    assign o_pins      = {7'b0, cnt < duty};

endmodule

`default_nettype wire

// ==== source/tick_timer.sv ====
`timescale 1ns/10ps
`default_nettype none
//********************
// Down-counting tick timer in full slot 2
// Count loads with the written size, zero extended
// Reads answer one cycle after the strobe
// Interrupt is sticky until any status write
//********************

module tick_timer (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire [5:0]                         i_addr_ofs,
    input  wire [periph_hub_pkg::DATA_W-1:0]  i_data_in,
    input  wire [1:0]                         i_write_n,
    input  wire [1:0]                         i_read_n,
    output logic [periph_hub_pkg::DATA_W-1:0] o_read_data,
    output logic                              o_ready,
    output logic [7:0]                        o_pins,
    output logic                              o_interrupt
);

    logic [periph_hub_pkg::DATA_W-1:0] count;
    logic [periph_hub_pkg::DATA_W-1:0] load_val;
    logic wr;
    logic rd;

    assign wr = (i_write_n != periph_hub_pkg::SIZE_NONE);
    assign rd = (i_read_n != periph_hub_pkg::SIZE_NONE);

    always_comb begin
        case (i_write_n)
            periph_hub_pkg::SIZE_BYTE: load_val = {24'h0, i_data_in[7:0]};
            periph_hub_pkg::SIZE_HALF: load_val = {16'h0, i_data_in[15:0]};
            default:                   load_val = i_data_in;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count       <= '0;
            o_interrupt <= 1'b0;
            o_ready     <= 1'b0;
        end else begin
            o_ready <= rd;
            if (wr && i_addr_ofs == periph_hub_pkg::TIMER_COUNT_OFS)
                count <= load_val;
            else if (count != '0)
                count <= count - 1'b1;
            if (wr && i_addr_ofs == periph_hub_pkg::TIMER_STATUS_OFS)
                o_interrupt <= 1'b0;
            // Last tick wins over a clear in the same cycle
            if (count == 1 && !(wr && i_addr_ofs == periph_hub_pkg::TIMER_COUNT_OFS))
                o_interrupt <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            if (i_addr_ofs == periph_hub_pkg::TIMER_COUNT_OFS)
                o_read_data <= count;
            else if (i_addr_ofs == periph_hub_pkg::TIMER_STATUS_OFS)
                o_read_data <= {{(periph_hub_pkg::DATA_W-1){1'b0}}, o_interrupt};
            else
                o_read_data <= '0;
        end
    end

    assign o_pins = {6'b0, count != '0, o_interrupt};    // Pin 1 running, pin 0 irq

endmodule

`default_nettype wire

// ==== tb/periph_hub_chk.sv ====
`timescale 1ns/10ps
`default_nettype none
//********************
// Bus timing and reset checks, bound into periph_hub
// Interrupt check holds until the first timer count write
//********************

module periph_hub_chk (
    input wire                              clk,
    input wire                              rst_n,
    input wire [periph_hub_pkg::ADDR_W-1:0] i_addr,
    input wire [1:0]                        i_data_write_n,
    input wire [1:0]                        i_data_read_n,
    input wire                              i_data_read_complete,
    input wire [periph_hub_pkg::DATA_W-1:0] i_data_out,
    input wire                              i_data_ready,
    input wire [15:2]                       i_user_interrupts,
    input wire                              i_audio_select
);

    logic timer_loaded;
    logic timer_count_write;

    assign timer_count_write = (i_addr[10:6] == {1'b0, periph_hub_pkg::SLOT_TIMER}) &&
                               (i_addr[5:0] == periph_hub_pkg::TIMER_COUNT_OFS) &&
                               (i_data_write_n != periph_hub_pkg::SIZE_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n)
            timer_loaded <= 1'b0;
        else if (timer_count_write)
            timer_loaded <= 1'b1;
    end

    ready_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!i_data_ready || i_data_write_n != periph_hub_pkg::SIZE_NONE))
        else $error("ready high in the first cycle after reset");

    state_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (i_user_interrupts == '0 && !i_audio_select))
        else $error("interrupts or audio select not cleared by reset");

    // Completion comes with the read still held
    data_held: assert property (@(posedge clk) disable iff (!rst_n)
        (i_data_ready && i_data_read_n != periph_hub_pkg::SIZE_NONE && !i_data_read_complete)
        |=> $stable(i_data_out))
        else $error("read data changed before completion");

    irq_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !timer_loaded |-> (i_user_interrupts == '0))
        else $error("interrupt raised before the timer was loaded");

endmodule

bind periph_hub periph_hub_chk u_chk (
    .clk                  (clk),
    .rst_n                (rst_n),
    .i_addr               (i_addr),
    .i_data_write_n       (i_data_write_n),
    .i_data_read_n        (i_data_read_n),
    .i_data_read_complete (i_data_read_complete),
    .i_data_out           (o_data_out),
    .i_data_ready         (o_data_ready),
    .i_user_interrupts    (o_user_interrupts),
    .i_audio_select       (o_audio_select)
);

`default_nettype wire

// ==== tb/periph_hub_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
//********************
// Testbench for the peripheral hub
// Reads are held until ready, then released with a completion pulse
// Bus timing and reset rules are checked by the bound checker
// Runs are limited to 2000 clock cycles
//********************

module periph_hub_tb;

    logic                              clk = 1'b0;
    logic                              rst_n;
    logic [7:0]                        i_ui_in;
    logic [periph_hub_pkg::ADDR_W-1:0] i_addr;
    logic [periph_hub_pkg::DATA_W-1:0] i_data_in;
    logic [1:0]                        i_data_write_n;
    logic [1:0]                        i_data_read_n;
    logic                              i_data_read_complete;
    wire  [periph_hub_pkg::DATA_W-1:0] o_data_out;
    wire                               o_data_ready;
    wire  [7:0]                        o_uo_out;
    wire                               o_audio;
    wire                               o_audio_select;
    wire  [15:2]                       o_user_interrupts;

    int          cycle_count = 0;
    bit          run_passed = 1'b0;
    bit          fail_reported = 1'b0;
    logic [31:0] rd_data;
    logic [7:0]  gpio_val;
    logic [7:0]  ui_val;
    int          pin0_highs;
    int          pin3_highs;
    int          waited;

    periph_hub UUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (i_ui_in),
        .i_addr               (i_addr),
        .i_data_in            (i_data_in),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_uo_out             (o_uo_out),
        .o_audio              (o_audio),
        .o_audio_select       (o_audio_select),
        .o_user_interrupts    (o_user_interrupts)
    );

    always #4 clk = ~clk;    // 8 ns period

    // Tests take about 700 cycles
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == 2000) begin
            $display("Timeout: the run did not finish within 2000 clock cycles");
            fail_reported = 1'b1;
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // A bound assertion that stops the run still ends with the verdict
    final begin
        if (!run_passed && !fail_reported)
            $display("Test failed");
    end

    function automatic logic [periph_hub_pkg::ADDR_W-1:0] full_addr(input logic [3:0] slot,
                                                                    input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [periph_hub_pkg::ADDR_W-1:0] byte_addr(input logic [3:0] slot,
                                                                    input logic [3:0] ofs);
        return {3'b100, slot, ofs};    // Bits 10:9 = 10, bit 8 unused
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            fail_reported = 1'b1;
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Write is taken at the second edge, ready is high in between
    task automatic bus_write(input logic [periph_hub_pkg::ADDR_W-1:0] addr,
                             input logic [1:0] size, input logic [31:0] data);
        @(posedge clk);
        i_addr         <= addr;
        i_data_in      <= data;
        i_data_write_n <= size;
        @(posedge clk);
        i_data_write_n <= periph_hub_pkg::SIZE_NONE;
    endtask

    task automatic bus_read(input logic [periph_hub_pkg::ADDR_W-1:0] addr,
                            input logic [1:0] size, output logic [31:0] data);
        @(posedge clk);
        i_addr        <= addr;
        i_data_read_n <= size;
        do
            @(negedge clk);
        while (o_data_ready !== 1'b1);
        data = o_data_out;
        @(posedge clk);
        i_data_read_complete <= 1'b1;
        i_data_read_n        <= periph_hub_pkg::SIZE_NONE;
        @(posedge clk);
        i_data_read_complete <= 1'b0;
    endtask

    task automatic count_pwm_pins();
        pin0_highs = 0;
        pin3_highs = 0;
        repeat (256) begin
            @(negedge clk);
            if (o_uo_out[0])
                pin0_highs++;
            if (o_uo_out[3])
                pin3_highs++;
        end
    endtask

    initial begin
        rst_n                <= 1'b0;
        i_ui_in              <= '0;
        i_addr               <= '0;
        i_data_in            <= '0;
        i_data_write_n       <= periph_hub_pkg::SIZE_NONE;
        i_data_read_n        <= periph_hub_pkg::SIZE_NONE;
        i_data_read_complete <= 1'b0;
        void'($urandom(32'h9a4a98c9));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // GPIO output register, pins and input readback
        gpio_val = 8'($urandom);
        ui_val   = 8'($urandom);
        @(posedge clk);
        i_ui_in <= ui_val;
        bus_write(full_addr(periph_hub_pkg::SLOT_GPIO, periph_hub_pkg::GPIO_OUT_OFS),
                  periph_hub_pkg::SIZE_BYTE, {24'h0, gpio_val});
        bus_read(full_addr(periph_hub_pkg::SLOT_GPIO, periph_hub_pkg::GPIO_OUT_OFS),
                 periph_hub_pkg::SIZE_BYTE, rd_data);
        check_equal("GPIO output readback", rd_data, {24'h0, gpio_val});
        @(negedge clk);
        check_equal("pins 7 to 2", {26'h0, o_uo_out[7:2]}, {26'h0, gpio_val[7:2]});
        bus_read(full_addr(periph_hub_pkg::SLOT_GPIO, periph_hub_pkg::GPIO_IN_OFS),
                 periph_hub_pkg::SIZE_BYTE, rd_data);
        check_equal("GPIO input readback", rd_data, {24'h0, ui_val});

        // PWM on pins 0 and 3; only pin 0 of the PWM carries the wave
        bus_write(full_addr(periph_hub_pkg::SLOT_GPIO, periph_hub_pkg::FUNC_SEL_OFS),
                  periph_hub_pkg::SIZE_BYTE, {27'h0, 1'b1, periph_hub_pkg::SLOT_PWM});
        bus_write(full_addr(periph_hub_pkg::SLOT_GPIO, periph_hub_pkg::FUNC_SEL_OFS + 6'd12),
                  periph_hub_pkg::SIZE_BYTE, {27'h0, 1'b1, periph_hub_pkg::SLOT_PWM});
        bus_write(byte_addr(periph_hub_pkg::SLOT_PWM, 4'd0), periph_hub_pkg::SIZE_BYTE, 32'h0);
        count_pwm_pins();
        check_equal("pin 0 highs at duty 0", pin0_highs, 0);
        check_equal("pin 3 highs at duty 0", pin3_highs, 0);
        bus_write(byte_addr(periph_hub_pkg::SLOT_PWM, 4'd0), periph_hub_pkg::SIZE_BYTE, 32'hff);
        count_pwm_pins();
        check_equal("pin 0 highs at duty 255", pin0_highs, 255);    // Counter below 255
        check_equal("pin 3 highs at duty 255", pin3_highs, 0);
        bus_read(full_addr(periph_hub_pkg::SLOT_GPIO, periph_hub_pkg::FUNC_SEL_OFS + 6'd12),
                 periph_hub_pkg::SIZE_BYTE, rd_data);
        check_equal("pin 3 select readback", rd_data, {27'h0, 1'b1, periph_hub_pkg::SLOT_PWM});
        bus_read(byte_addr(periph_hub_pkg::SLOT_PWM, 4'd0), periph_hub_pkg::SIZE_BYTE, rd_data);
        check_equal("PWM duty readback", rd_data, 32'hff);
        bus_write(full_addr(periph_hub_pkg::SLOT_GPIO, periph_hub_pkg::FUNC_SEL_OFS),
                  periph_hub_pkg::SIZE_BYTE, {27'h0, 1'b0, periph_hub_pkg::SLOT_TIMER});

        // Empty slots read zero
        bus_read(full_addr(4'd5, 6'h00), 2'b10, rd_data);    // Word access
        check_equal("empty full slot 5", rd_data, 32'h0);
        bus_read(byte_addr(4'd3, 4'd0), periph_hub_pkg::SIZE_BYTE, rd_data);
        check_equal("empty byte slot 3", rd_data, 32'h0);

        // Timer count down to the interrupt
        bus_write(full_addr(periph_hub_pkg::SLOT_TIMER, periph_hub_pkg::TIMER_COUNT_OFS),
                  2'b10, 32'd20);
        @(negedge clk);
        check_equal("pin 1 while counting", {31'h0, o_uo_out[1]}, 32'h1);
        waited = 0;
        while (o_user_interrupts[2] !== 1'b1 && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        check_equal("interrupt 2 within 40 cycles", {31'h0, o_user_interrupts[2]}, 32'h1);
        check_equal("pin 0 with interrupt", {31'h0, o_uo_out[0]}, 32'h1);
        bus_read(full_addr(periph_hub_pkg::SLOT_TIMER, periph_hub_pkg::TIMER_COUNT_OFS),
                 2'b10, rd_data);
        check_equal("timer count at end", rd_data, 32'h0);
        bus_read(full_addr(periph_hub_pkg::SLOT_TIMER, periph_hub_pkg::TIMER_STATUS_OFS),
                 2'b10, rd_data);
        check_equal("timer status set", rd_data, 32'h1);
        bus_write(full_addr(periph_hub_pkg::SLOT_TIMER, periph_hub_pkg::TIMER_STATUS_OFS),
                  2'b10, 32'h0);
        @(negedge clk);
        check_equal("interrupt 2 after clear", {31'h0, o_user_interrupts[2]}, 32'h0);
        bus_read(full_addr(periph_hub_pkg::SLOT_TIMER, periph_hub_pkg::TIMER_STATUS_OFS),
                 2'b10, rd_data);
        check_equal("timer status cleared", rd_data, 32'h0);

        // Audio from GPIO bit 7, one cycle behind
        bus_write(full_addr(periph_hub_pkg::SLOT_GPIO, periph_hub_pkg::AUDIO_SEL_OFS),
                  periph_hub_pkg::SIZE_BYTE, {28'h0, 1'b1, periph_hub_pkg::AUDIO_GPIO7});
        @(negedge clk);
        check_equal("audio select", {31'h0, o_audio_select}, 32'h1);
        bus_write(full_addr(periph_hub_pkg::SLOT_GPIO, periph_hub_pkg::GPIO_OUT_OFS),
                  periph_hub_pkg::SIZE_BYTE, {24'h0, ~gpio_val});
        @(negedge clk);
        check_equal("audio before update", {31'h0, o_audio}, {31'h0, gpio_val[7]});
        @(negedge clk);
        check_equal("audio one cycle later", {31'h0, o_audio}, {31'h0, ~gpio_val[7]});

        run_passed = 1'b1;
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
